// ==== src/rv32i_pkg.sv ====
package rv32i_pkg;

    // data and address width
    localparam int XLEN = 32;

    // one enable bit per byte lane
    localparam int BE_W = XLEN / 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [BE_W-1:0] be_t;

    // load funct3 encodings
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // store funct3 encodings
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

endpackage : rv32i_pkg

// ==== src/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    // memory address source
    typedef enum logic {
        sel_pc  = 1'b0,
        sel_alu = 1'b1
    } marmux_e;

    // register file writeback source
    typedef enum logic [1:0] {
        alu_out   = 2'b00,
        u_imm     = 2'b01,
        mem_rdata = 2'b10
    } regfilemux_e;

    // control for the memory stage
    typedef struct packed {
        logic                     mem_read;
        logic                     mem_write;
        rv32i_pkg::load_funct3_e  load_funct3;
        rv32i_pkg::store_funct3_e store_funct3;
        marmux_e                  mar_sel;
    } mem_ctrl_t;

    // decode/execute payload
    typedef struct packed {
        rv32i_pkg::word_t pc;
        rv32i_pkg::word_t rs1;
        rv32i_pkg::word_t rs2;
        rv32i_pkg::word_t imm;
        rv32i_pkg::word_t u_imm;
        mem_ctrl_t        ctrl;
        regfilemux_e      wb_sel;
    } dec_exe_t;

    // execute/memory payload
    typedef struct packed {
        rv32i_pkg::word_t pc;
        rv32i_pkg::word_t alu;
        rv32i_pkg::word_t u_imm;
        mem_ctrl_t        ctrl;
        regfilemux_e      wb_sel;
    } exe_mem_t;

    // memory/writeback payload
    typedef struct packed {
        rv32i_pkg::word_t pc;
        rv32i_pkg::word_t alu;
        rv32i_pkg::word_t u_imm;
        rv32i_pkg::word_t rdata;
        regfilemux_e      wb_sel;
    } mem_wb_t;

endpackage : pipe_ctrl_pkg

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;

    rv32i_pkg::word_t addr;
    rv32i_pkg::word_t wdata;
    rv32i_pkg::be_t   be;
    logic             rd;
    logic             wr;

    // execute side builds the request
    modport gen (
        output addr,
        output wdata,
        output be,
        output rd,
        output wr
    );

    // memory port register samples it
    modport port (
        input addr,
        input wdata,
        input be,
        input rd,
        input wr
    );

endinterface : mem_req_if

// ==== src/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type      payload_t = logic [rv32i_pkg::XLEN-1:0],
    parameter payload_t RESET_VAL = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     adv_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // valid follows upstream on every strobe including bubbles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (adv_i) begin
            valid_q <= valid_i;
        end
    end

    // payload only moves with a real item
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_q <= RESET_VAL;
        end else if (adv_i && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule : stage_reg

// ==== src/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  pipe_ctrl_pkg::dec_exe_t de_i,
    output pipe_ctrl_pkg::exe_mem_t em_o,
    mem_req_if.gen                  req
);

    rv32i_pkg::word_t alu;
    rv32i_pkg::word_t mar;
    rv32i_pkg::word_t aligned;
    rv32i_pkg::word_t addr;
    rv32i_pkg::be_t   be;

    assign alu = de_i.rs1 + de_i.imm;

    always_comb begin
        case (de_i.ctrl.mar_sel)
            pipe_ctrl_pkg::sel_pc:  mar = de_i.pc;
            default:                mar = alu;
        endcase
    end

    assign aligned = {mar[rv32i_pkg::XLEN-1:2], 2'b00};

    // loads win over stores if both are flagged
    always_comb begin
        be   = '0;
        addr = mar;
        if (de_i.ctrl.mem_read) begin
            case (de_i.ctrl.load_funct3)
                rv32i_pkg::lw: begin
                    be = 4'b1111;
                end
                rv32i_pkg::lh, rv32i_pkg::lhu: begin
                    be   = rv32i_pkg::be_t'(4'b0011) << mar[1:0];
                    addr = aligned;
                end
                rv32i_pkg::lb, rv32i_pkg::lbu: begin
                    be   = rv32i_pkg::be_t'(4'b0001) << mar[1:0];
                    addr = aligned;
                end
                default: ;
            endcase
        end else if (de_i.ctrl.mem_write) begin
            case (de_i.ctrl.store_funct3)
                rv32i_pkg::sw: begin
                    be = 4'b1111;
                end
                rv32i_pkg::sh: begin
                    be   = rv32i_pkg::be_t'(4'b0011) << mar[1:0];
                    addr = aligned;
                end
                rv32i_pkg::sb: begin
                    be   = rv32i_pkg::be_t'(4'b0001) << mar[1:0];
                    addr = aligned;
                end
                default: ;
            endcase
        end
    end

    assign req.addr  = addr;
    assign req.wdata = de_i.rs2;
    assign req.be    = be;
    assign req.rd    = de_i.ctrl.mem_read;
    assign req.wr    = de_i.ctrl.mem_write & ~de_i.ctrl.mem_read;

    assign em_o.pc     = de_i.pc;
    assign em_o.alu    = alu;
    assign em_o.u_imm  = de_i.u_imm;
    assign em_o.ctrl   = de_i.ctrl;
    assign em_o.wb_sel = de_i.wb_sel;

endmodule : exe_stage

// ==== src/mem_port_reg.sv ====
`timescale 1ns/1ps

module mem_port_reg (
    input  logic             clk,
    input  logic             rst,
    input  logic             adv_i,
    input  logic             de_valid_i,
    mem_req_if.port          req,
    output rv32i_pkg::word_t mem_addr_o,
    output rv32i_pkg::word_t mem_wdata_o,
    output rv32i_pkg::be_t   mem_be_o
);

    logic             load;
    rv32i_pkg::word_t addr_q;
    rv32i_pkg::word_t wdata_q;
    rv32i_pkg::be_t   be_q;

    // only real memory ops touch the port, everything else holds
    assign load = adv_i & de_valid_i & (req.rd | req.wr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_q  <= '0;
            wdata_q <= '0;
            be_q    <= '0;
        end else if (load) begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            be_q    <= req.be;
        end
    end

    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = wdata_q;
    assign mem_be_o    = be_q;

endmodule : mem_port_reg

// ==== src/rv_mem_pipe.sv ====
`timescale 1ns/1ps

module rv_mem_pipe #(
    parameter rv32i_pkg::word_t RESET_PC = 32'h4000_0000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       adv_i,

    input  logic                       in_valid_i,
    input  rv32i_pkg::word_t           pc_i,
    input  rv32i_pkg::word_t           rs1_i,
    input  rv32i_pkg::word_t           rs2_i,
    input  rv32i_pkg::word_t           imm_i,
    input  rv32i_pkg::word_t           u_imm_i,
    input  logic                       mem_read_i,
    input  logic                       mem_write_i,
    input  logic [2:0]                 funct3_i,
    input  pipe_ctrl_pkg::marmux_e     mar_sel_i,
    input  pipe_ctrl_pkg::regfilemux_e wb_sel_i,

    input  rv32i_pkg::word_t           mem_rdata_i,
    output rv32i_pkg::word_t           mem_addr_o,
    output rv32i_pkg::word_t           mem_wdata_o,
    output rv32i_pkg::be_t             mem_be_o,
    output logic                       mem_read_o,
    output logic                       mem_write_o,

    output logic                       wb_valid_o,
    output rv32i_pkg::word_t           wb_pc_o,
    output rv32i_pkg::word_t           wb_alu_o,
    output rv32i_pkg::word_t           wb_u_imm_o,
    output rv32i_pkg::word_t           wb_rdata_o,
    output pipe_ctrl_pkg::regfilemux_e wb_sel_o
);

    localparam pipe_ctrl_pkg::mem_ctrl_t CTRL_RESET = '{
        mem_read:     1'b0,
        mem_write:    1'b0,
        load_funct3:  rv32i_pkg::lw,
        store_funct3: rv32i_pkg::sw,
        mar_sel:      pipe_ctrl_pkg::sel_pc
    };

    localparam pipe_ctrl_pkg::dec_exe_t DE_RESET = '{
        pc:     RESET_PC,
        rs1:    '0,
        rs2:    '0,
        imm:    '0,
        u_imm:  '0,
        ctrl:   CTRL_RESET,
        wb_sel: pipe_ctrl_pkg::alu_out
    };

    localparam pipe_ctrl_pkg::exe_mem_t EM_RESET = '{
        pc:     RESET_PC,
        alu:    '0,
        u_imm:  '0,
        ctrl:   CTRL_RESET,
        wb_sel: pipe_ctrl_pkg::alu_out
    };

    localparam pipe_ctrl_pkg::mem_wb_t MW_RESET = '{
        pc:     RESET_PC,
        alu:    '0,
        u_imm:  '0,
        rdata:  '0,
        wb_sel: pipe_ctrl_pkg::alu_out
    };

    pipe_ctrl_pkg::dec_exe_t de_in;
    pipe_ctrl_pkg::dec_exe_t de_q;
    pipe_ctrl_pkg::exe_mem_t em_in;
    pipe_ctrl_pkg::exe_mem_t em_q;
    pipe_ctrl_pkg::mem_wb_t  mw_in;
    pipe_ctrl_pkg::mem_wb_t  mw_q;
    logic                    de_valid;
    logic                    em_valid;
    logic                    mw_valid;

    mem_req_if mem_req ();

    // one funct3 field feeds both load and store views
    assign de_in.pc                = pc_i;
    assign de_in.rs1               = rs1_i;
    assign de_in.rs2               = rs2_i;
    assign de_in.imm               = imm_i;
    assign de_in.u_imm             = u_imm_i;
    assign de_in.ctrl.mem_read     = mem_read_i;
    assign de_in.ctrl.mem_write    = mem_write_i;
    assign de_in.ctrl.load_funct3  = rv32i_pkg::load_funct3_e'(funct3_i);
    assign de_in.ctrl.store_funct3 = rv32i_pkg::store_funct3_e'(funct3_i);
    assign de_in.ctrl.mar_sel      = mar_sel_i;
    assign de_in.wb_sel            = wb_sel_i;

    stage_reg #(
        .payload_t (pipe_ctrl_pkg::dec_exe_t),
        .RESET_VAL (DE_RESET)
    ) u_de (
        .clk     (clk),
        .rst     (rst),
        .adv_i   (adv_i),
        .valid_i (in_valid_i),
        .data_i  (de_in),
        .valid_o (de_valid),
        .data_o  (de_q)
    );

    exe_stage u_exe (
        .de_i (de_q),
        .em_o (em_in),
        .req  (mem_req.gen)
    );

    // primed alongside the exe/mem register so the memory sees the request right away
    mem_port_reg u_port (
        .clk         (clk),
        .rst         (rst),
        .adv_i       (adv_i),
        .de_valid_i  (de_valid),
        .req         (mem_req.port),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_be_o    (mem_be_o)
    );

    stage_reg #(
        .payload_t (pipe_ctrl_pkg::exe_mem_t),
        .RESET_VAL (EM_RESET)
    ) u_em (
        .clk     (clk),
        .rst     (rst),
        .adv_i   (adv_i),
        .valid_i (de_valid),
        .data_i  (em_in),
        .valid_o (em_valid),
        .data_o  (em_q)
    );

    assign mem_read_o  = em_valid & em_q.ctrl.mem_read;
    assign mem_write_o = em_valid & em_q.ctrl.mem_write;

    assign mw_in.pc     = em_q.pc;
    assign mw_in.alu    = em_q.alu;
    assign mw_in.u_imm  = em_q.u_imm;
    assign mw_in.rdata  = mem_rdata_i;
    assign mw_in.wb_sel = em_q.wb_sel;

    stage_reg #(
        .payload_t (pipe_ctrl_pkg::mem_wb_t),
        .RESET_VAL (MW_RESET)
    ) u_mw (
        .clk     (clk),
        .rst     (rst),
        .adv_i   (adv_i),
        .valid_i (em_valid),
        .data_i  (mw_in),
        .valid_o (mw_valid),
        .data_o  (mw_q)
    );

    assign wb_valid_o = mw_valid;
    assign wb_pc_o    = mw_q.pc;
    assign wb_alu_o   = mw_q.alu;
    assign wb_u_imm_o = mw_q.u_imm;
    assign wb_rdata_o = mw_q.rdata;
    assign wb_sel_o   = mw_q.wb_sel;

endmodule : rv_mem_pipe

// ==== dv/tb_rv_mem_pipe.sv ====
`timescale 1ns/1ps

module tb_rv_mem_pipe;

    localparam rv32i_pkg::word_t RESET_PC = 32'h8000_0100;
    localparam int N_DIRECTED    = 68;
    localparam int N_RANDOM      = 300;
    localparam int STROBE_BUDGET = N_DIRECTED + N_RANDOM + 3;
    localparam int CYCLE_LIMIT   = 4 * STROBE_BUDGET + 100;

    typedef struct packed {
        rv32i_pkg::word_t addr;
        rv32i_pkg::word_t wdata;
        rv32i_pkg::be_t   be;
        rv32i_pkg::word_t alu;
    } exp_t;

    typedef struct packed {
        logic                    valid;
        pipe_ctrl_pkg::dec_exe_t de;
    } slot_t;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic                       adv_i;
    logic                       in_valid_i;
    rv32i_pkg::word_t           pc_i;
    rv32i_pkg::word_t           rs1_i;
    rv32i_pkg::word_t           rs2_i;
    rv32i_pkg::word_t           imm_i;
    rv32i_pkg::word_t           u_imm_i;
    logic                       mem_read_i;
    logic                       mem_write_i;
    logic [2:0]                 funct3_i;
    pipe_ctrl_pkg::marmux_e     mar_sel_i;
    pipe_ctrl_pkg::regfilemux_e wb_sel_i;
    rv32i_pkg::word_t           mem_rdata_i;
    rv32i_pkg::word_t           mem_addr_o;
    rv32i_pkg::word_t           mem_wdata_o;
    rv32i_pkg::be_t             mem_be_o;
    logic                       mem_read_o;
    logic                       mem_write_o;
    logic                       wb_valid_o;
    rv32i_pkg::word_t           wb_pc_o;
    rv32i_pkg::word_t           wb_alu_o;
    rv32i_pkg::word_t           wb_u_imm_o;
    rv32i_pkg::word_t           wb_rdata_o;
    pipe_ctrl_pkg::regfilemux_e wb_sel_o;

    logic [31:0] lfsr_state = 32'h1cd7bcfd;
    string       test_name = "reset";
    int          error_count = 0;
    int          check_count = 0;
    int          strobe_count = 0;
    int          cycle_count = 0;

    // pipe[0] is decode/execute, pipe[1] execute/memory, pipe[2] memory/writeback
    slot_t            pipe[$];
    rv32i_pkg::word_t exp_addr;
    rv32i_pkg::word_t exp_wdata;
    rv32i_pkg::be_t   exp_be;
    rv32i_pkg::word_t exp_wb_pc;
    rv32i_pkg::word_t exp_wb_alu;
    rv32i_pkg::word_t exp_wb_u_imm;
    rv32i_pkg::word_t exp_wb_rdata;
    logic [1:0]       exp_wb_sel;

    rv_mem_pipe #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .adv_i       (adv_i),
        .in_valid_i  (in_valid_i),
        .pc_i        (pc_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .imm_i       (imm_i),
        .u_imm_i     (u_imm_i),
        .mem_read_i  (mem_read_i),
        .mem_write_i (mem_write_i),
        .funct3_i    (funct3_i),
        .mar_sel_i   (mar_sel_i),
        .wb_sel_i    (wb_sel_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_be_o    (mem_be_o),
        .mem_read_o  (mem_read_o),
        .mem_write_o (mem_write_o),
        .wb_valid_o  (wb_valid_o),
        .wb_pc_o     (wb_pc_o),
        .wb_alu_o    (wb_alu_o),
        .wb_u_imm_o  (wb_u_imm_o),
        .wb_rdata_o  (wb_rdata_o),
        .wb_sel_o    (wb_sel_o)
    );

    always #20 clk = ~clk;

    // galois taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // expected execute results straight from the ISA rules
    function automatic exp_t ref_model(input pipe_ctrl_pkg::dec_exe_t d);
        exp_t        e;
        logic [31:0] mar;
        logic [7:0]  lanes;
        int          width;
        e.alu   = d.rs1 + d.imm;
        e.wdata = d.rs2;
        mar     = (d.ctrl.mar_sel == pipe_ctrl_pkg::sel_pc) ? d.pc : e.alu;
        width   = 0;
        if (d.ctrl.mem_read) begin
            case (d.ctrl.load_funct3)
                rv32i_pkg::lw:                 width = 4;
                rv32i_pkg::lh, rv32i_pkg::lhu: width = 2;
                rv32i_pkg::lb, rv32i_pkg::lbu: width = 1;
                default:                       width = 0;
            endcase
        end else if (d.ctrl.mem_write) begin
            case (d.ctrl.store_funct3)
                rv32i_pkg::sw: width = 4;
                rv32i_pkg::sh: width = 2;
                rv32i_pkg::sb: width = 1;
                default:       width = 0;
            endcase
        end
        e.addr = mar;
        e.be   = 4'b0000;
        if (width == 4) begin
            e.be = 4'b1111;
        end else if (width != 0) begin
            // lanes past byte 3 fall off
            lanes  = ((8'd1 << width) - 8'd1) << mar[1:0];
            e.be   = lanes[3:0];
            e.addr = mar & ~32'd3;
        end
        return e;
    endfunction

    function automatic pipe_ctrl_pkg::dec_exe_t set_ctrl(
        input pipe_ctrl_pkg::dec_exe_t d,
        input logic                    rd,
        input logic                    wr,
        input logic [2:0]              f3,
        input pipe_ctrl_pkg::marmux_e  ms
    );
        pipe_ctrl_pkg::dec_exe_t r;
        r                   = d;
        r.ctrl.mem_read     = rd;
        r.ctrl.mem_write    = wr;
        r.ctrl.load_funct3  = rv32i_pkg::load_funct3_e'(f3);
        r.ctrl.store_funct3 = rv32i_pkg::store_funct3_e'(f3);
        r.ctrl.mar_sel      = ms;
        return r;
    endfunction

    task automatic random_item(output pipe_ctrl_pkg::dec_exe_t d);
        logic [31:0] v;
        logic [31:0] c;
        draw_bits(32, v);
        d.pc = v;
        draw_bits(32, v);
        d.rs1 = v;
        draw_bits(32, v);
        d.rs2 = v;
        draw_bits(32, v);
        d.imm = v;
        draw_bits(32, v);
        d.u_imm = v;
        draw_bits(6, c);
        d = set_ctrl(d, c[5], c[4], c[3:1], pipe_ctrl_pkg::marmux_e'(c[0]));
        draw_bits(2, v);
        d.wb_sel = (v[1:0] == 2'b11) ? pipe_ctrl_pkg::alu_out
                                     : pipe_ctrl_pkg::regfilemux_e'(v[1:0]);
    endtask

    // idle cycles refresh the read data, then one strobe carries the item
    task automatic send_item(input int gap, input logic valid, input pipe_ctrl_pkg::dec_exe_t d);
        logic [31:0] v;
        repeat (gap) begin
            @(posedge clk);
            adv_i <= 1'b0;
            draw_bits(32, v);
            mem_rdata_i <= v;
        end
        @(posedge clk);
        adv_i       <= 1'b1;
        in_valid_i  <= valid;
        pc_i        <= d.pc;
        rs1_i       <= d.rs1;
        rs2_i       <= d.rs2;
        imm_i       <= d.imm;
        u_imm_i     <= d.u_imm;
        mem_read_i  <= d.ctrl.mem_read;
        mem_write_i <= d.ctrl.mem_write;
        funct3_i    <= d.ctrl.load_funct3;
        mar_sel_i   <= d.ctrl.mar_sel;
        wb_sel_i    <= d.wb_sel;
    endtask

    task automatic check_value(input string sig, input logic [31:0] expv, input logic [31:0] actv);
        check_count++;
        if (actv !== expv) begin
            error_count++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, sig, expv, actv);
        end
    endtask

    // pipeline model stepped on every strobe
    always @(posedge clk or posedge rst) begin
        slot_t entry;
        exp_t  e;
        if (rst) begin
            pipe = {};
            entry = '0;
            repeat (3) pipe.push_back(entry);
            exp_addr     = '0;
            exp_wdata    = '0;
            exp_be       = '0;
            exp_wb_pc    = RESET_PC;
            exp_wb_alu   = '0;
            exp_wb_u_imm = '0;
            exp_wb_rdata = '0;
            exp_wb_sel   = pipe_ctrl_pkg::alu_out;
        end else if (adv_i) begin
            strobe_count++;
            if (pipe[0].valid && (pipe[0].de.ctrl.mem_read || pipe[0].de.ctrl.mem_write)) begin
                e         = ref_model(pipe[0].de);
                exp_addr  = e.addr;
                exp_wdata = e.wdata;
                exp_be    = e.be;
            end
            if (pipe[1].valid) begin
                e            = ref_model(pipe[1].de);
                exp_wb_pc    = pipe[1].de.pc;
                exp_wb_alu   = e.alu;
                exp_wb_u_imm = pipe[1].de.u_imm;
                exp_wb_rdata = mem_rdata_i;
                exp_wb_sel   = pipe[1].de.wb_sel;
            end
            entry.valid = in_valid_i;
            entry.de    = set_ctrl('0, mem_read_i, mem_write_i, funct3_i, mar_sel_i);
            entry.de.pc     = pc_i;
            entry.de.rs1    = rs1_i;
            entry.de.rs2    = rs2_i;
            entry.de.imm    = imm_i;
            entry.de.u_imm  = u_imm_i;
            entry.de.wb_sel = wb_sel_i;
            pipe.push_front(entry);
            void'(pipe.pop_back());
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (!rst && pipe.size() == 3) begin
            check_value("mem_addr_o", exp_addr, mem_addr_o);
            check_value("mem_wdata_o", exp_wdata, mem_wdata_o);
            check_value("mem_be_o", exp_be, mem_be_o);
            check_value("mem_read_o", pipe[1].valid & pipe[1].de.ctrl.mem_read, mem_read_o);
            check_value("mem_write_o", pipe[1].valid & pipe[1].de.ctrl.mem_write, mem_write_o);
            check_value("wb_valid_o", pipe[2].valid, wb_valid_o);
            check_value("wb_pc_o", exp_wb_pc, wb_pc_o);
            check_value("wb_alu_o", exp_wb_alu, wb_alu_o);
            check_value("wb_u_imm_o", exp_wb_u_imm, wb_u_imm_o);
            check_value("wb_rdata_o", exp_wb_rdata, wb_rdata_o);
            check_value("wb_sel_o", exp_wb_sel, wb_sel_o);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("simulation stopped at the cycle limit of %0d", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        pipe_ctrl_pkg::dec_exe_t d;
        pipe_ctrl_pkg::dec_exe_t nm;
        logic [31:0]             rnd;
        adv_i       = 1'b0;
        in_valid_i  = 1'b0;
        pc_i        = '0;
        rs1_i       = '0;
        rs2_i       = '0;
        imm_i       = '0;
        u_imm_i     = '0;
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
        funct3_i    = 3'b000;
        mar_sel_i   = pipe_ctrl_pkg::sel_alu;
        wb_sel_i    = pipe_ctrl_pkg::alu_out;
        mem_rdata_i = '0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // one quiet cycle so the reset values get checked
        @(posedge clk);

        test_name = "load_offsets";
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int off = 0; off < 4; off++) begin
                random_item(d);
                d.rs1 = 32'h2000_0100 + (f3 << 4);
                d.imm = off;
                d = set_ctrl(d, 1'b1, 1'b0, f3, pipe_ctrl_pkg::sel_alu);
                send_item(1, 1'b1, d);
            end
        end

        // non-memory items in between must leave the port alone
        test_name = "store_widths";
        for (int f3 = 0; f3 < 4; f3++) begin
            for (int off = 0; off < 4; off++) begin
                random_item(d);
                d.rs1 = 32'h3000_0200 + (f3 << 4);
                d.imm = 32'hffff_fffc + off;
                d = set_ctrl(d, 1'b0, 1'b1, f3, pipe_ctrl_pkg::sel_alu);
                send_item(1, 1'b1, d);
                random_item(nm);
                nm = set_ctrl(nm, 1'b0, 1'b0, f3, pipe_ctrl_pkg::sel_alu);
                send_item(1, 1'b1, nm);
            end
        end

        test_name = "mar_from_pc";
        for (int off = 0; off < 4; off++) begin
            random_item(d);
            d.pc = 32'h0000_8000 + off;
            d = set_ctrl(d, 1'b1, 1'b0, rv32i_pkg::lb, pipe_ctrl_pkg::sel_pc);
            send_item(1, 1'b1, d);
        end

        test_name = "random_bubbles";
        for (int i = 0; i < N_RANDOM; i++) begin
            draw_bits(2, rnd);
            nm.pc = rnd;
            draw_bits(1, rnd);
            random_item(d);
            send_item(nm.pc[1:0], rnd[0], d);
        end

        test_name = "flush";
        repeat (3) send_item(0, 1'b0, d);
        @(posedge clk);
        adv_i <= 1'b0;
        repeat (2) @(posedge clk);

        if (check_count == 0) begin
            error_count++;
            $display("no output was ever compared");
        end
        $display("checks %0d, errors %0d, strobes %0d", check_count, error_count, strobe_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_rv_mem_pipe

// ==== vlog.f ====
src/rv32i_pkg.sv
src/pipe_ctrl_pkg.sv
src/mem_req_if.sv
src/stage_reg.sv
src/exe_stage.sv
src/mem_port_reg.sv
src/rv_mem_pipe.sv
dv/tb_rv_mem_pipe.sv

// ==== Bender.yml ====
package:
  name: rv_mem_pipe

sources:
  # packages first, then the design bottom-up
  - src/rv32i_pkg.sv
  - src/pipe_ctrl_pkg.sv
  - src/mem_req_if.sv
  - src/stage_reg.sv
  - src/exe_stage.sv
  - src/mem_port_reg.sv
  - src/rv_mem_pipe.sv

  - target: test
    files:
      - dv/tb_rv_mem_pipe.sv
